//--- design/cache_pkg.sv
// shared definitions for the burst data cache
// widths of the word port and the burst port, address split constants,
// and the enums used by the miss controller

package cache_pkg;

  // core word port
  localparam int addr_bits = 32;
  localparam int word_bits = 32;
  localparam int byte_lanes = 4;

  // address split |tag|line|column|00|
  localparam int zero_bits = 2;
  localparam int column_bits = 3;
  localparam int columns = 2 ** column_bits;

  // lowest bit of the column index and of the line index in an address
  localparam int column_lsb = zero_bits;
  localparam int line_lsb = zero_bits + column_bits;

  // burst RAM side, one line moves as four 64-bit beats
  localparam int beat_bits = 64;
  localparam int beats_per_line = 4;
  localparam int beat_ix_bits = 2;

  // miss handling states
  typedef enum logic [2:0] {
    idle,
    evict_beat,
    fill_wait,
    fill_beat,
    tag_update
  } ctrl_state_e;

  // burst RAM command
  typedef enum logic {
    br_read  = 1'b0,
    br_write = 1'b1
  } br_cmd_e;

endpackage

//--- design/line_ram.sv
// byte enabled single port memory, one 32-bit word per entry
// write is clocked, read is asynchronous so lookups see the current address

module line_ram #(
  parameter int addr_bits_p = 8
) (
  input  logic                                clk,
  input  logic [addr_bits_p-1:0]              addr,
  input  logic [cache_pkg::byte_lanes-1:0]    wr_en,
  input  logic [cache_pkg::word_bits-1:0]     wr_data,
  output logic [cache_pkg::word_bits-1:0]     rd_data
);

  localparam int depth = 2 ** addr_bits_p;

  logic [cache_pkg::word_bits-1:0] mem [depth];

  // each strobe covers one byte lane
  always_ff @(posedge clk) begin
    for (int b = 0; b < cache_pkg::byte_lanes; b++) begin
      if (wr_en[b]) begin
        mem[addr][8*b +: 8] <= wr_data[8*b +: 8];
      end
    end
  end

  assign rd_data = mem[addr];

endmodule

//--- design/cache_store.sv
// cache storage with tag RAM, per line valid and dirty flags and column RAMs
// produces the hit signal and steers core writes and line fills into the columns

module cache_store #(
  parameter int line_ix_bits = 8,
  localparam int tag_bits = cache_pkg::addr_bits - line_ix_bits
                            - cache_pkg::column_bits - cache_pkg::zero_bits
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [line_ix_bits-1:0]               line_ix,
  input  logic [cache_pkg::column_bits-1:0]     column_ix,
  input  logic [tag_bits-1:0]                   req_tag,
  input  logic [cache_pkg::word_bits-1:0]       data_in,
  input  logic [cache_pkg::byte_lanes-1:0]      write_enable,
  output logic [cache_pkg::word_bits-1:0]       data_out,
  output logic                                  hit,
  output logic                                  victim_dirty,
  output logic [tag_bits-1:0]                   victim_tag,
  input  logic [cache_pkg::beat_ix_bits-1:0]    beat_sel,
  output logic [cache_pkg::beat_bits-1:0]       beat_data,
  input  logic                                  fill_en,
  input  logic [cache_pkg::beat_ix_bits-1:0]    fill_beat,
  input  logic [cache_pkg::beat_bits-1:0]       fill_data,
  input  logic                                  tag_update
);

  localparam int lines = 2 ** line_ix_bits;

  logic [lines-1:0] valid_q;
  logic [lines-1:0] dirty_q;

  logic [cache_pkg::word_bits-1:0]  tag_word;
  logic [cache_pkg::word_bits-1:0]  col_rd [cache_pkg::columns];
  logic                             write_hit;

  // tag RAM keeps the tag zero extended to a full word
  line_ram #(
    .addr_bits_p(line_ix_bits)
  ) tag_ram (
    .clk    (clk),
    .addr   (line_ix),
    .wr_en  ({cache_pkg::byte_lanes{tag_update}}),
    .wr_data({{(cache_pkg::word_bits - tag_bits){1'b0}}, req_tag}),
    .rd_data(tag_word)
  );

  assign victim_tag = tag_word[tag_bits-1:0];
  assign hit = valid_q[line_ix] && (victim_tag == req_tag);
  assign victim_dirty = valid_q[line_ix] && dirty_q[line_ix];
  assign write_hit = hit && (write_enable != '0);

  // valid set and dirty cleared once a fresh line is in place
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (tag_update) begin
      valid_q[line_ix] <= 1'b1;
      dirty_q[line_ix] <= 1'b0;
    end else if (write_hit) begin
      dirty_q[line_ix] <= 1'b1;
    end
  end

  // two columns per beat, even column in the low half
  for (genvar c = 0; c < cache_pkg::columns; c++) begin : g_col
    localparam logic [cache_pkg::column_bits-1:0] col_id = c;

    logic [cache_pkg::byte_lanes-1:0] col_wr_en;
    logic [cache_pkg::word_bits-1:0]  col_wr_data;

    always_comb begin
      col_wr_en = '0;
      col_wr_data = data_in;
      if (fill_en) begin
        if (fill_beat == col_id[cache_pkg::column_bits-1:1]) begin
          col_wr_en = '1;
        end
        col_wr_data = fill_data[(c % 2) * cache_pkg::word_bits +: cache_pkg::word_bits];
      end else if (write_hit && column_ix == col_id) begin
        col_wr_en = write_enable;
      end
    end

    line_ram #(
      .addr_bits_p(line_ix_bits)
    ) col_ram (
      .clk    (clk),
      .addr   (line_ix),
      .wr_en  (col_wr_en),
      .wr_data(col_wr_data),
      .rd_data(col_rd[c])
    );
  end

  assign data_out = col_rd[column_ix];

  // beat used by the write back burst
  assign beat_data = {col_rd[{beat_sel, 1'b1}], col_rd[{beat_sel, 1'b0}]};

endmodule

//--- design/burst_controller.sv
// miss controller for the burst cache
// writes back a dirty victim line as one write burst, then fills the line
// with one read burst and updates the tag

module burst_controller #(
  parameter int line_ix_bits = 8,
  parameter int ram_depth_bits = 12,
  localparam int tag_bits = cache_pkg::addr_bits - line_ix_bits
                            - cache_pkg::column_bits - cache_pkg::zero_bits
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                hit,
  input  logic                                victim_dirty,
  input  logic [tag_bits-1:0]                 victim_tag,
  input  logic [line_ix_bits-1:0]             line_ix,
  input  logic [tag_bits-1:0]                 req_tag,
  input  logic [cache_pkg::beat_bits-1:0]     beat_data,
  output logic [cache_pkg::beat_ix_bits-1:0]  beat_sel,
  output logic                                fill_en,
  output logic [cache_pkg::beat_ix_bits-1:0]  fill_beat,
  output logic [cache_pkg::beat_bits-1:0]     fill_data,
  output logic                                tag_update,
  output cache_pkg::br_cmd_e                  br_cmd,
  output logic                                br_cmd_en,
  output logic [ram_depth_bits-1:0]           br_addr,
  output logic [cache_pkg::beat_bits-1:0]     br_wr_data,
  input  logic [cache_pkg::beat_bits-1:0]     br_rd_data,
  input  logic                                br_rd_data_valid,
  input  logic                                br_busy
);

  localparam int line_addr_bits = tag_bits + line_ix_bits + cache_pkg::beat_ix_bits;
  localparam int last_beat = cache_pkg::beats_per_line - 1;

  cache_pkg::ctrl_state_e state;

  logic [cache_pkg::beat_ix_bits-1:0] beat_cnt;
  logic                               evicted;

  logic [line_addr_bits-1:0] victim_addr;
  logic [line_addr_bits-1:0] req_addr;

  logic miss_go;
  logic start_evict;
  logic start_fill;
  logic evict_load;
  logic fill_done;
  logic capture;

  // line number times four gives the first beat of the line
  assign victim_addr = {victim_tag, line_ix, {cache_pkg::beat_ix_bits{1'b0}}};
  assign req_addr = {req_tag, line_ix, {cache_pkg::beat_ix_bits{1'b0}}};

  always_comb begin
    miss_go = (state == cache_pkg::idle) && !hit && !br_busy;
    // a line that was already written back goes straight to the fill
    start_evict = miss_go && victim_dirty && !evicted;
    start_fill = miss_go && !(victim_dirty && !evicted);
    // beat 0 is loaded together with the write strobe
    evict_load = (state == cache_pkg::evict_beat) && (beat_cnt != '0);
    fill_done = (state == cache_pkg::fill_beat) && fill_en
                && (fill_beat == last_beat[cache_pkg::beat_ix_bits-1:0]);
    capture = br_rd_data_valid
              && ((state == cache_pkg::fill_wait)
                  || ((state == cache_pkg::fill_beat) && !fill_done));
  end

  assign beat_sel = beat_cnt;
  assign tag_update = (state == cache_pkg::tag_update);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cache_pkg::idle;
      beat_cnt <= '0;
      evicted <= 1'b0;
      br_cmd_en <= 1'b0;
      fill_en <= 1'b0;
      fill_beat <= '0;
    end else begin
      br_cmd_en <= start_evict || start_fill;
      fill_en <= capture;
      if (capture) begin
        fill_beat <= (state == cache_pkg::fill_wait) ? '0 : fill_beat + 1'b1;
      end

      case (state)
        cache_pkg::idle: begin
          if (start_evict) begin
            beat_cnt <= 2'd1;
            state <= cache_pkg::evict_beat;
          end else if (start_fill) begin
            state <= cache_pkg::fill_wait;
          end
        end

        // four cycles, the counter is back at zero in the last one
        cache_pkg::evict_beat: begin
          if (beat_cnt == '0) begin
            evicted <= 1'b1;
            state <= cache_pkg::idle;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end

        cache_pkg::fill_wait: begin
          if (capture) begin
            state <= cache_pkg::fill_beat;
          end
        end

        cache_pkg::fill_beat: begin
          if (fill_done) begin
            state <= cache_pkg::tag_update;
          end
        end

        cache_pkg::tag_update: begin
          evicted <= 1'b0;
          state <= cache_pkg::idle;
        end

        default: begin
          state <= cache_pkg::idle;
        end
      endcase
    end
  end

  // command, address and beat data registers
  always_ff @(posedge clk) begin
    if (start_evict) begin
      br_cmd <= cache_pkg::br_write;
      br_addr <= victim_addr[ram_depth_bits-1:0];
    end else if (start_fill) begin
      br_cmd <= cache_pkg::br_read;
      br_addr <= req_addr[ram_depth_bits-1:0];
    end
    if (start_evict || evict_load) begin
      br_wr_data <= beat_data;
    end
    if (capture) begin
      fill_data <= br_rd_data;
    end
  end

endmodule

//--- design/burst_cache.sv
// direct mapped write back cache between a 32-bit word port and a burst RAM
// splits the core address and connects the storage to the miss controller

module burst_cache #(
  parameter int line_ix_bits = 8,
  parameter int ram_depth_bits = 12
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [cache_pkg::addr_bits-1:0]     address,
  input  logic [cache_pkg::word_bits-1:0]     data_in,
  input  logic [cache_pkg::byte_lanes-1:0]    write_enable,
  output logic [cache_pkg::word_bits-1:0]     data_out,
  output logic                                data_out_ready,
  output logic                                busy,
  output cache_pkg::br_cmd_e                  br_cmd,
  output logic                                br_cmd_en,
  output logic [ram_depth_bits-1:0]           br_addr,
  output logic [cache_pkg::beat_bits-1:0]     br_wr_data,
  input  logic [cache_pkg::beat_bits-1:0]     br_rd_data,
  input  logic                                br_rd_data_valid,
  input  logic                                br_busy
);

  localparam int tag_bits = cache_pkg::addr_bits - line_ix_bits
                            - cache_pkg::column_bits - cache_pkg::zero_bits;

  logic [cache_pkg::column_bits-1:0]   column_ix;
  logic [line_ix_bits-1:0]             line_ix;
  logic [tag_bits-1:0]                 req_tag;

  logic                                hit;
  logic                                victim_dirty;
  logic [tag_bits-1:0]                 victim_tag;
  logic [cache_pkg::beat_ix_bits-1:0]  beat_sel;
  logic [cache_pkg::beat_bits-1:0]     beat_data;
  logic                                fill_en;
  logic [cache_pkg::beat_ix_bits-1:0]  fill_beat;
  logic [cache_pkg::beat_bits-1:0]     fill_data;
  logic                                tag_update;

  // |tag|line|column|00|
  assign column_ix = address[cache_pkg::line_lsb-1:cache_pkg::column_lsb];
  assign line_ix = address[cache_pkg::line_lsb +: line_ix_bits];
  assign req_tag = address[cache_pkg::addr_bits-1 -: tag_bits];

  assign busy = !hit;
  assign data_out_ready = hit && (write_enable == '0);

  cache_store #(
    .line_ix_bits(line_ix_bits)
  ) store (
    .clk         (clk),
    .rst         (rst),
    .line_ix     (line_ix),
    .column_ix   (column_ix),
    .req_tag     (req_tag),
    .data_in     (data_in),
    .write_enable(write_enable),
    .data_out    (data_out),
    .hit         (hit),
    .victim_dirty(victim_dirty),
    .victim_tag  (victim_tag),
    .beat_sel    (beat_sel),
    .beat_data   (beat_data),
    .fill_en     (fill_en),
    .fill_beat   (fill_beat),
    .fill_data   (fill_data),
    .tag_update  (tag_update)
  );

  burst_controller #(
    .line_ix_bits  (line_ix_bits),
    .ram_depth_bits(ram_depth_bits)
  ) ctrl (
    .clk             (clk),
    .rst             (rst),
    .hit             (hit),
    .victim_dirty    (victim_dirty),
    .victim_tag      (victim_tag),
    .line_ix         (line_ix),
    .req_tag         (req_tag),
    .beat_data       (beat_data),
    .beat_sel        (beat_sel),
    .fill_en         (fill_en),
    .fill_beat       (fill_beat),
    .fill_data       (fill_data),
    .tag_update      (tag_update),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid),
    .br_busy         (br_busy)
  );

endmodule

//--- bench/burst_ram_model.sv
// behavioural burst RAM with 64-bit beats
// four beat write and read bursts, a variable read latency and a short
// busy window after every command

module burst_ram_model #(
  parameter int depth_bits = 12
) (
  input  logic                   clk,
  input  logic                   rst,
  input  cache_pkg::br_cmd_e     br_cmd,
  input  logic                   br_cmd_en,
  input  logic [depth_bits-1:0]  br_addr,
  input  logic [63:0]            br_wr_data,
  output logic [63:0]            br_rd_data,
  output logic                   br_rd_data_valid,
  output logic                   br_busy,
  input  logic [2:0]             read_latency,
  input  logic [2:0]             busy_len
);

  localparam int depth = 2 ** depth_bits;

  logic [63:0]           mem [depth];
  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic [1:0]            wr_left;
  logic [2:0]            rd_wait;
  logic [2:0]            rd_left;
  logic [2:0]            busy_cnt;

  // word w of the memory starts out as a value unique to w
  function automatic logic [31:0] init_word(input int w);
    return (w * 32'h0101_0101) ^ 32'h5a3c_96e1;
  endfunction

  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = {init_word(2 * i + 1), init_word(2 * i)};
    end
  end

  assign br_busy = (busy_cnt != 3'd0);

  always @(posedge clk) begin
    if (rst) begin
      wr_left <= 2'd0;
      rd_wait <= 3'd0;
      rd_left <= 3'd0;
      busy_cnt <= 3'd0;
      br_rd_data_valid <= 1'b0;
    end else begin
      br_rd_data_valid <= 1'b0;
      if (br_cmd_en) begin
        busy_cnt <= busy_len;
        if (br_cmd == cache_pkg::br_write) begin
          // beat 0 comes with the strobe
          mem[br_addr] <= br_wr_data;
          wr_ptr <= br_addr + 1'b1;
          wr_left <= 2'd3;
        end else begin
          rd_ptr <= br_addr;
          rd_wait <= read_latency;
        end
      end else if (busy_cnt != 3'd0) begin
        busy_cnt <= busy_cnt - 1'b1;
      end
      if (wr_left != 2'd0) begin
        mem[wr_ptr] <= br_wr_data;
        wr_ptr <= wr_ptr + 1'b1;
        wr_left <= wr_left - 1'b1;
      end
      if (rd_wait != 3'd0) begin
        rd_wait <= rd_wait - 1'b1;
        if (rd_wait == 3'd1) begin
          rd_left <= 3'd4;
        end
      end
      // four consecutive valid beats, lowest first
      if (rd_left != 3'd0) begin
        br_rd_data <= mem[rd_ptr];
        br_rd_data_valid <= 1'b1;
        rd_ptr <= rd_ptr + 1'b1;
        rd_left <= rd_left - 1'b1;
      end
    end
  end

endmodule

//--- bench/burst_cache_assert.sv
// protocol checks for the burst cache, bound into the top level
// command strobe shape, the burst RAM busy handshake and read ready

module burst_cache_assert (
  input logic clk,
  input logic rst,
  input logic br_cmd_en,
  input logic br_busy,
  input logic data_out_ready,
  input logic busy,
  input logic fill_en,
  input logic tag_update
);

  strobe_one_cycle: assert property (
    @(posedge clk) disable iff (rst) br_cmd_en |=> !br_cmd_en
  ) else $error("br_cmd_en stayed high for more than one cycle");

  // a command only starts while the burst RAM is free
  strobe_not_busy: assert property (
    @(posedge clk) disable iff (rst) $rose(br_cmd_en) |-> !br_busy
  ) else $error("br_cmd_en rose while br_busy was high");

  // read data is only offered once the line fill is over
  ready_after_fill: assert property (
    @(posedge clk) disable iff (rst) data_out_ready |-> !busy && !fill_en && !tag_update
  ) else $error("data_out_ready high while a miss was still in progress");

  strobe_low_after_reset: assert property (
    @(posedge clk) rst |=> !br_cmd_en
  ) else $error("br_cmd_en high in the cycle after reset");

endmodule

//--- bench/burst_cache_tb.sv
// testbench for the burst cache
// drives the word port, checks every ready read against a shadow memory
// and watches the burst commands for write back behaviour

module burst_cache_tb;

  localparam int line_ix_bits = 4;
  localparam int ram_depth_bits = 12;
  localparam int drive_delay = 4;
  // about 330 requests, a dirty miss with the longest waits stays under 30 cycles
  localparam int max_cycles = 20000;

  logic                      clk;
  logic                      rst;
  logic [31:0]               address;
  logic [31:0]               data_in;
  logic [3:0]                write_enable;
  logic [31:0]               data_out;
  logic                      data_out_ready;
  logic                      busy;
  cache_pkg::br_cmd_e        br_cmd;
  logic                      br_cmd_en;
  logic [ram_depth_bits-1:0] br_addr;
  logic [63:0]               br_wr_data;
  logic [63:0]               br_rd_data;
  logic                      br_rd_data_valid;
  logic                      br_busy;
  logic [2:0]                read_latency;
  logic [2:0]                busy_len;

  logic [31:0]               shadow [8192];
  logic [ram_depth_bits-1:0] write_cmds [$];
  int                        read_cmds;
  int                        reads_issued;
  int                        reads_checked;
  int                        cycle_count;
  string                     test_name;
  logic [31:0]               stim_seed;
  logic [31:0]               timing_seed;

  burst_cache #(
    .line_ix_bits  (line_ix_bits),
    .ram_depth_bits(ram_depth_bits)
  ) UUT (
    .clk(clk), .rst(rst), .address(address), .data_in(data_in),
    .write_enable(write_enable), .data_out(data_out), .data_out_ready(data_out_ready),
    .busy(busy), .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr),
    .br_wr_data(br_wr_data), .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid), .br_busy(br_busy)
  );

  burst_ram_model #(
    .depth_bits(ram_depth_bits)
  ) ram_model (
    .clk(clk), .rst(rst), .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr),
    .br_wr_data(br_wr_data), .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid), .br_busy(br_busy),
    .read_latency(read_latency), .busy_len(busy_len)
  );

  bind burst_cache burst_cache_assert protocol_check (
    .clk(clk), .rst(rst), .br_cmd_en(br_cmd_en), .br_busy(br_busy),
    .data_out_ready(data_out_ready), .busy(busy), .fill_en(fill_en),
    .tag_update(tag_update)
  );

  function automatic logic [31:0] next_random(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] pattern_word(input int w);
    return (w * 32'h0101_0101) ^ 32'h5a3c_96e1;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                              input logic [31:0] data,
                                              input logic [3:0] be);
    logic [31:0] result;
    result = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = data[8*b +: 8];
      end
    end
    return result;
  endfunction

  // word a read of addr must return
  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    return shadow[addr[14:2]];
  endfunction

  // line number times four, cut to the burst address width
  function automatic logic [ram_depth_bits-1:0] line_beat_addr(input logic [31:0] addr);
    logic [31:0] beat;
    beat = (addr >> 5) * 4;
    return beat[ram_depth_bits-1:0];
  endfunction

  task automatic check_equal(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERROR %s %s expected %h actual %h", test_name, what, expected, actual);
      $display("TB FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // burst RAM timing changes every cycle
  initial begin
    timing_seed = 32'hd096;
    read_latency = 3'd2;
    busy_len = 3'd1;
    forever begin
      @(posedge clk);
      #drive_delay;
      timing_seed = next_random(timing_seed);
      read_latency = 3'd2 + {1'b0, timing_seed[21:20]};
      busy_len = 3'd1 + {1'b0, timing_seed[25:24]} + {2'b00, timing_seed[27]};
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run stopped after %0d clock cycles in test %s", cycle_count, test_name);
    $display("TB FAILED");
    $fatal(1, "timeout");
  end

  // read data compared mid cycle, inputs and outputs are settled
  always @(negedge clk) begin
    logic [31:0] want;
    if (!rst && data_out_ready) begin
      want = expected_word(address);
      reads_checked++;
      assert (data_out === want) else begin
        $display("ERROR %s read %h expected %h actual %h", test_name, address, want, data_out);
        $display("TB FAILED");
        $fatal(1, "read data mismatch");
      end
    end
  end

  always @(negedge clk) begin
    if (!rst && br_cmd_en) begin
      if (br_cmd == cache_pkg::br_write) begin
        write_cmds.push_back(br_addr);
      end else begin
        read_cmds++;
      end
    end
  end

  // returns just after the edge that completes the request
  task automatic wait_done(output int stall);
    stall = 0;
    @(negedge clk);
    while (busy) begin
      stall++;
      @(negedge clk);
    end
    @(posedge clk);
    #drive_delay;
  endtask

  task automatic read_word(input logic [31:0] addr, output int stall);
    address = addr;
    write_enable = 4'h0;
    reads_issued++;
    wait_done(stall);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] be, output int stall);
    address = addr;
    data_in = data;
    write_enable = be;
    wait_done(stall);
    shadow[addr[14:2]] = merge_bytes(shadow[addr[14:2]], data, be);
    write_enable = 4'h0;
  endtask

  task automatic cold_reads();
    int          stall;
    logic [31:0] addr;
    test_name = "cold_reads";
    for (int i = 0; i < 12; i++) begin
      addr = 32'h0000_0124 * i;
      read_word(addr, stall);
      assert (stall > 0) else begin
        $display("cold read of %h completed without a miss", addr);
        $display("TB FAILED");
        $fatal(1, "missing miss");
      end
    end
  endtask

  task automatic write_hit_merge();
    int stall;
    test_name = "write_hit_merge";
    read_word(32'h0000_0340, stall);
    write_word(32'h0000_0340, 32'hdead_beef, 4'b0101, stall);
    check_equal("write hit stall", 0, stall);
    read_word(32'h0000_0340, stall);
    write_word(32'h0000_035c, 32'h1234_5678, 4'b1000, stall);
    check_equal("write hit stall", 0, stall);
    read_word(32'h0000_035c, stall);
    read_word(32'h0000_0344, stall);
  endtask

  task automatic dirty_eviction();
    int          stall;
    logic [12:0] w;
    logic [31:0] model_word;
    logic [31:0] a_addr;
    a_addr = 32'h0000_0a68;
    test_name = "dirty_eviction";
    write_word(a_addr, 32'hcafe_f00d, 4'b0110, stall);
    write_cmds.delete();
    // same line index, different tag
    read_word(a_addr + 32'h0000_1000, stall);
    check_equal("write command count", 1, write_cmds.size());
    check_equal("write command address", {20'h0, line_beat_addr(a_addr)}, {20'h0, write_cmds[0]});
    for (int c = 0; c < 8; c++) begin
      w = {a_addr[14:5], 3'(c)};
      model_word = w[0] ? ram_model.mem[w[12:1]][63:32] : ram_model.mem[w[12:1]][31:0];
      check_equal("written back word", shadow[w], model_word);
    end
    read_word(a_addr, stall);
  endtask

  task automatic clean_replace();
    int stall;
    int reads_before;
    test_name = "clean_replace";
    read_word(32'h0000_0ca0, stall);
    write_cmds.delete();
    reads_before = read_cmds;
    read_word(32'h0000_2ca4, stall);
    read_word(32'h0000_0cb8, stall);
    check_equal("write command count", 0, write_cmds.size());
    check_equal("read command count", reads_before + 2, read_cmds);
  endtask

  task automatic random_mix();
    int          stall;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    test_name = "random_mix";
    for (int n = 0; n < 300; n++) begin
      stim_seed = next_random(stim_seed);
      addr = 32'h0000_1000 + {21'h0, stim_seed[26:18], 2'b00};
      be = stim_seed[31:28];
      // roughly three in eight requests are writes
      if (stim_seed[17:15] < 3'd3) begin
        stim_seed = next_random(stim_seed);
        data = stim_seed;
        if (be == 4'h0) begin
          be = 4'hf;
        end
        write_word(addr, data, be, stall);
      end else begin
        read_word(addr, stall);
      end
    end
  endtask

  initial begin
    rst = 1'b1;
    address = 32'h0;
    data_in = 32'h0;
    write_enable = 4'h0;
    stim_seed = 32'hd096;
    read_cmds = 0;
    reads_issued = 0;
    reads_checked = 0;
    test_name = "reset";
    for (int w = 0; w < 8192; w++) begin
      shadow[w] = pattern_word(w);
    end
    repeat (16) @(posedge clk);
    #drive_delay;
    rst = 1'b0;

    cold_reads();
    write_hit_merge();
    dirty_eviction();
    clean_replace();
    random_mix();

    test_name = "summary";
    if (reads_checked == reads_issued) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("ERROR %s reads checked expected %0d actual %0d", test_name, reads_issued,
               reads_checked);
      $display("TB FAILED");
      $fatal(1, "read count mismatch");
    end
  end

endmodule

//--- list.f
design/cache_pkg.sv
design/line_ram.sv
design/cache_store.sv
design/burst_controller.sv
design/burst_cache.sv
bench/burst_ram_model.sv
bench/burst_cache_assert.sv
bench/burst_cache_tb.sv

//--- run.sh
#!/bin/sh
# compile the burst cache testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module burst_cache_tb \
  -f list.f \
  --Mdir "$build_dir" \
  -o burst_cache_tb
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$build_dir/burst_cache_tb" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" "$log_file"; then
  exit 0
else
  echo "pass message not found in $log_file"
  exit 1
fi
